/* common/vcache_cfg.svh */
// sizes shared by the cache banks, router and backing memory
// bank count, block words and sets must be powers of two
// backing memory holds VC_MEM_BLOCKS / VC_NUM_BANKS blocks per bank, higher tags alias
`ifndef VCACHE_CFG_SVH
`define VCACHE_CFG_SVH

`define VC_NUM_BANKS   4
`define VC_SETS        16
`define VC_BLOCK_WORDS 4
`define VC_DATA_WIDTH  32
`define VC_ADDR_WIDTH  16

// input queue depth per bank, also the starting credit count
`define VC_CREDITS     2

`define VC_MEM_BLOCKS  1024

// derived widths
`define VC_BLOCK_WIDTH    (`VC_BLOCK_WORDS * `VC_DATA_WIDTH)
`define VC_BLK_ADDR_WIDTH (`VC_ADDR_WIDTH - $clog2(`VC_NUM_BANKS))

`endif

/* common/vcache_pkg.sv */
// types for the requester port, load responses and the bank to memory link
// addresses are word addresses, no byte enables
`include "vcache_cfg.svh"

package vcache_pkg;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } vc_op_e;

  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_LOOKUP = 3'd1,
    ST_EVICT  = 3'd2,
    ST_FILL   = 3'd3,
    ST_RESP   = 3'd4
  } vc_state_e;

  typedef struct packed {
    vc_op_e                    op;
    logic [`VC_ADDR_WIDTH-1:0] addr;
    logic [`VC_DATA_WIDTH-1:0] data;
  } vc_req_s;

  typedef struct packed {
    logic [`VC_ADDR_WIDTH-1:0] addr;
    logic [`VC_DATA_WIDTH-1:0] data;
  } vc_resp_s;

  // block address keeps the word field, always zero on this link
  typedef struct packed {
    logic                          write_not_read;
    logic [`VC_BLK_ADDR_WIDTH-1:0] addr;
    logic [`VC_BLOCK_WIDTH-1:0]    data;
  } dma_req_s;

endpackage

/* design/vcache_router.sv */
// steers requester traffic to the banks by the low address bits
// a request to a bank without credit stalls the port, even if others are free
`timescale 1ns/1ps
`include "vcache_cfg.svh"

module vcache_router (
  input  logic                                      core_clk,
  input  logic                                      rst_n_i,
  input  logic                                      req_v_i,
  input  vcache_pkg::vc_req_s                       req_i,
  output logic                                      req_ready_o,
  output logic [`VC_NUM_BANKS-1:0]                  bank_v_o,
  output vcache_pkg::vc_req_s [`VC_NUM_BANKS-1:0]   bank_req_o,
  input  logic [`VC_NUM_BANKS-1:0]                  credit_return_i
);

  localparam int BW = $clog2(`VC_NUM_BANKS);
  localparam int CW = $clog2(`VC_CREDITS + 1);

  logic [CW-1:0] credit_q [`VC_NUM_BANKS];
  logic [BW-1:0] sel;

  // bank field sits in the lowest word address bits
  assign sel = req_i.addr[BW-1:0];

  assign req_ready_o = (credit_q[sel] != '0);

  always_comb begin
    for (int b = 0; b < `VC_NUM_BANKS; b++) begin
      bank_v_o[b]   = req_v_i && req_ready_o && (sel == BW'(b));
      bank_req_o[b] = req_i;
    end
  end

  // one credit per queue slot in the bank
  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < `VC_NUM_BANKS; b++) begin
        credit_q[b] <= CW'(`VC_CREDITS);
      end
    end else begin
      for (int b = 0; b < `VC_NUM_BANKS; b++) begin
        if (bank_v_o[b] && !credit_return_i[b]) begin
          credit_q[b] <= credit_q[b] - 1'b1;
        end else if (!bank_v_o[b] && credit_return_i[b]) begin
          // saturate at the queue depth
          if (credit_q[b] != CW'(`VC_CREDITS)) begin
            credit_q[b] <= credit_q[b] + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* vcache/vcache_bank.sv */
// blocking direct-mapped write-back cache bank, one miss at a time
// loads answer in request order, stores give no response
// queue has no overflow guard, the router's credits keep it from filling past depth
`timescale 1ns/1ps
`include "vcache_cfg.svh"

module vcache_bank (
  input  logic                        core_clk,
  input  logic                        rst_n_i,
  input  logic                        req_v_i,
  input  vcache_pkg::vc_req_s         req_i,
  output logic                        credit_return_o,
  output logic                        resp_v_o,
  output vcache_pkg::vc_resp_s        resp_o,
  output logic                        dma_v_o,
  output vcache_pkg::dma_req_s        dma_req_o,
  input  logic                        dma_yumi_i,
  input  logic                        fill_v_i,
  input  logic [`VC_BLOCK_WIDTH-1:0]  fill_data_i
);

  import vcache_pkg::*;

  localparam int BANK_BITS = $clog2(`VC_NUM_BANKS);
  localparam int WORD_BITS = $clog2(`VC_BLOCK_WORDS);
  localparam int SET_BITS  = $clog2(`VC_SETS);
  localparam int TAG_W     = `VC_ADDR_WIDTH - BANK_BITS - WORD_BITS - SET_BITS;
  localparam int QPW       = (`VC_CREDITS > 1) ? $clog2(`VC_CREDITS) : 1;
  localparam int QCW       = $clog2(`VC_CREDITS + 1);

  vc_req_s        q_mem [`VC_CREDITS];
  logic [QPW-1:0] wr_ptr_q;
  logic [QPW-1:0] rd_ptr_q;
  logic [QCW-1:0] count_q;
  logic           pop;

  vc_state_e                 state_q;
  vc_req_s                   cur_q;
  logic                      fill_sent_q;
  logic [`VC_DATA_WIDTH-1:0] resp_data_q;

  logic [TAG_W-1:0]           tag_mem [`VC_SETS];
  logic [`VC_BLOCK_WIDTH-1:0] data_mem [`VC_SETS];
  logic [`VC_SETS-1:0]        valid_q;
  logic [`VC_SETS-1:0]        dirty_q;

  logic [TAG_W-1:0]           cur_tag;
  logic [SET_BITS-1:0]        cur_set;
  logic [WORD_BITS-1:0]       cur_word;
  logic [`VC_BLOCK_WIDTH-1:0] rd_line;
  logic                       hit;
  logic                       store_hit;
  logic                       fill_done;
  logic                       line_we;
  logic [`VC_BLOCK_WIDTH-1:0] line_wdata;

  function automatic logic [`VC_BLOCK_WIDTH-1:0] put_word(
    input logic [`VC_BLOCK_WIDTH-1:0] line,
    input logic [WORD_BITS-1:0]       idx,
    input logic [`VC_DATA_WIDTH-1:0]  word
  );
    logic [`VC_BLOCK_WIDTH-1:0] res;
    res = line;
    res[idx*`VC_DATA_WIDTH +: `VC_DATA_WIDTH] = word;
    return res;
  endfunction

  // tag | set | word | bank
  assign cur_tag  = cur_q.addr[`VC_ADDR_WIDTH-1 -: TAG_W];
  assign cur_set  = cur_q.addr[BANK_BITS+WORD_BITS +: SET_BITS];
  assign cur_word = cur_q.addr[BANK_BITS +: WORD_BITS];
  assign rd_line  = data_mem[cur_set];

  assign hit       = valid_q[cur_set] && (tag_mem[cur_set] == cur_tag);
  assign store_hit = (state_q == ST_LOOKUP) && hit && (cur_q.op == OP_STORE);
  assign fill_done = (state_q == ST_FILL) && fill_sent_q && fill_v_i;
  assign line_we   = store_hit || fill_done;

  always_comb begin
    if (fill_done) begin
      line_wdata = (cur_q.op == OP_STORE) ? put_word(fill_data_i, cur_word, cur_q.data)
                                          : fill_data_i;
    end else begin
      line_wdata = put_word(rd_line, cur_word, cur_q.data);
    end
  end

  assign pop             = (state_q == ST_IDLE) && (count_q != '0);
  assign credit_return_o = pop;

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_v_i) begin
        wr_ptr_q <= (wr_ptr_q == QPW'(`VC_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == QPW'(`VC_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + QCW'(req_v_i) - QCW'(pop);
    end
  end

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      fill_sent_q <= 1'b0;
      valid_q     <= '0;
      dirty_q     <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pop) state_q <= ST_LOOKUP;
        end
        ST_LOOKUP: begin
          if (hit) begin
            if (cur_q.op == OP_STORE) begin
              dirty_q[cur_set] <= 1'b1;
              state_q          <= ST_IDLE;
            end else begin
              state_q <= ST_RESP;
            end
          end else if (valid_q[cur_set] && dirty_q[cur_set]) begin
            state_q <= ST_EVICT;
          end else begin
            state_q <= ST_FILL;
          end
        end
        ST_EVICT: begin
          if (dma_yumi_i) state_q <= ST_FILL;
        end
        ST_FILL: begin
          if (!fill_sent_q) begin
            if (dma_yumi_i) fill_sent_q <= 1'b1;
          end else if (fill_v_i) begin
            fill_sent_q      <= 1'b0;
            valid_q[cur_set] <= 1'b1;
            dirty_q[cur_set] <= (cur_q.op == OP_STORE);
            state_q          <= (cur_q.op == OP_STORE) ? ST_IDLE : ST_RESP;
          end
        end
        ST_RESP: begin
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_v_i) q_mem[wr_ptr_q] <= req_i;
    if (pop) cur_q <= q_mem[rd_ptr_q];
    if (line_we) data_mem[cur_set] <= line_wdata;
    if (fill_done) tag_mem[cur_set] <= cur_tag;
    if ((state_q == ST_LOOKUP) && hit) begin
      resp_data_q <= rd_line[cur_word*`VC_DATA_WIDTH +: `VC_DATA_WIDTH];
    end else if (fill_done) begin
      resp_data_q <= fill_data_i[cur_word*`VC_DATA_WIDTH +: `VC_DATA_WIDTH];
    end
  end

  assign resp_v_o = (state_q == ST_RESP);

  always_comb begin
    resp_o.addr = cur_q.addr;
    resp_o.data = resp_data_q;
  end

  // read request held until granted, then wait for the fill
  assign dma_v_o = (state_q == ST_EVICT) || ((state_q == ST_FILL) && !fill_sent_q);

  always_comb begin
    dma_req_o.write_not_read = (state_q == ST_EVICT);
    if (state_q == ST_EVICT) begin
      dma_req_o.addr = {tag_mem[cur_set], cur_set, {WORD_BITS{1'b0}}};
    end else begin
      dma_req_o.addr = {cur_tag, cur_set, {WORD_BITS{1'b0}}};
    end
    dma_req_o.data = rd_line;
  end

endmodule

/* design/dma_mem_arbiter.sv */
// round-robin grant of bank block transfers into one block memory
// no grant in the cycle a fill is returned, so fills never come back to back
// memory index is bank number plus low block address bits, contents start undefined
`timescale 1ns/1ps
`include "vcache_cfg.svh"

module dma_mem_arbiter (
  input  logic                                      core_clk,
  input  logic                                      rst_n_i,
  input  logic [`VC_NUM_BANKS-1:0]                  dma_v_i,
  input  vcache_pkg::dma_req_s [`VC_NUM_BANKS-1:0]  dma_req_i,
  output logic [`VC_NUM_BANKS-1:0]                  dma_yumi_o,
  output logic                                      fill_v_o,
  output logic [`VC_BLOCK_WIDTH-1:0]                fill_data_o
);

  import vcache_pkg::*;

  localparam int NB        = `VC_NUM_BANKS;
  localparam int BW        = $clog2(NB);
  localparam int IW        = $clog2(`VC_MEM_BLOCKS);
  localparam int WORD_BITS = $clog2(`VC_BLOCK_WORDS);

  logic [`VC_BLOCK_WIDTH-1:0] mem [`VC_MEM_BLOCKS];

  logic [BW-1:0] last_q;
  logic [BW-1:0] cand;
  logic [BW-1:0] gnt_idx;
  logic          gnt_any;
  dma_req_s      gnt_req;
  logic [IW-1:0] mem_idx;

  // search starts one past the last granted bank
  always_comb begin
    gnt_any = 1'b0;
    gnt_idx = last_q;
    cand    = '0;
    for (int k = 1; k <= NB; k++) begin
      cand = BW'((int'(last_q) + k) % NB);
      if (!gnt_any && !fill_v_o && dma_v_i[cand]) begin
        gnt_any = 1'b1;
        gnt_idx = cand;
      end
    end
  end

  always_comb begin
    dma_yumi_o          = '0;
    dma_yumi_o[gnt_idx] = gnt_any;
  end

  assign gnt_req = dma_req_i[gnt_idx];
  assign mem_idx = {gnt_idx, gnt_req.addr[WORD_BITS +: IW-BW]};

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q   <= BW'(NB - 1);
      fill_v_o <= 1'b0;
    end else begin
      fill_v_o <= gnt_any && !gnt_req.write_not_read;
      if (gnt_any) last_q <= gnt_idx;
    end
  end

  always_ff @(posedge core_clk) begin
    if (gnt_any && gnt_req.write_not_read) begin
      mem[mem_idx] <= gnt_req.data;
    end
    if (gnt_any && !gnt_req.write_not_read) begin
      fill_data_o <= mem[mem_idx];
    end
  end

endmodule

/* design/vcache_top.sv */
// router, cache banks and backing memory
// load responses come out per bank with no back-pressure
`timescale 1ns/1ps
`include "vcache_cfg.svh"

module vcache_top (
  input  logic                                      core_clk,
  input  logic                                      rst_n_i,
  input  logic                                      req_v_i,
  input  vcache_pkg::vc_req_s                       req_i,
  output logic                                      req_ready_o,
  output logic [`VC_NUM_BANKS-1:0]                  resp_v_o,
  output vcache_pkg::vc_resp_s [`VC_NUM_BANKS-1:0]  resp_o
);

  import vcache_pkg::*;

  logic [`VC_NUM_BANKS-1:0]     bank_v;
  vc_req_s [`VC_NUM_BANKS-1:0]  bank_req;
  logic [`VC_NUM_BANKS-1:0]     credit_return;

  logic [`VC_NUM_BANKS-1:0]     dma_v;
  dma_req_s [`VC_NUM_BANKS-1:0] dma_req;
  logic [`VC_NUM_BANKS-1:0]     dma_yumi;
  logic                         fill_v;
  logic [`VC_BLOCK_WIDTH-1:0]   fill_data;

  vcache_router router (
    .core_clk        (core_clk),
    .rst_n_i         (rst_n_i),
    .req_v_i         (req_v_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .bank_v_o        (bank_v),
    .bank_req_o      (bank_req),
    .credit_return_i (credit_return)
  );

  for (genvar i = 0; i < `VC_NUM_BANKS; i++) begin : g_bank
    vcache_bank bank (
      .core_clk        (core_clk),
      .rst_n_i         (rst_n_i),
      .req_v_i         (bank_v[i]),
      .req_i           (bank_req[i]),
      .credit_return_o (credit_return[i]),
      .resp_v_o        (resp_v_o[i]),
      .resp_o          (resp_o[i]),
      .dma_v_o         (dma_v[i]),
      .dma_req_o       (dma_req[i]),
      .dma_yumi_i      (dma_yumi[i]),
      .fill_v_i        (fill_v),
      .fill_data_i     (fill_data)
    );
  end

  dma_mem_arbiter arbiter (
    .core_clk    (core_clk),
    .rst_n_i     (rst_n_i),
    .dma_v_i     (dma_v),
    .dma_req_i   (dma_req),
    .dma_yumi_o  (dma_yumi),
    .fill_v_o    (fill_v),
    .fill_data_o (fill_data)
  );

endmodule

/* verification/vcache_chk.sv */
// protocol checks on router credits, arbiter grants and the fill pulse
// credit input mirrors the router's per-bank counters
`timescale 1ns/1ps
`include "vcache_cfg.svh"

module vcache_chk (
  input logic                                core_clk,
  input logic                                rst_n_i,
  input logic [`VC_NUM_BANKS-1:0]            resp_v_i,
  input logic [`VC_NUM_BANKS-1:0]            bank_v_i,
  input logic [$clog2(`VC_CREDITS+1)-1:0]    credit_i [`VC_NUM_BANKS],
  input logic [`VC_NUM_BANKS-1:0]            dma_yumi_i,
  input logic                                fill_v_i
);

  int unsigned fail_cnt = 0;

  resp_quiet_in_reset: assert property (@(posedge core_clk) !rst_n_i |-> resp_v_i == '0)
    else begin
      $error("load response valid while in reset");
      fail_cnt++;
    end

  for (genvar b = 0; b < `VC_NUM_BANKS; b++) begin : g_credit
    send_needs_credit: assert property (@(posedge core_clk) disable iff (!rst_n_i)
      bank_v_i[b] |-> credit_i[b] != '0)
      else begin
        $error("bank %0d received a request with no credit left", b);
        fail_cnt++;
      end

    credit_in_range: assert property (@(posedge core_clk) disable iff (!rst_n_i)
      credit_i[b] <= `VC_CREDITS)
      else begin
        $error("bank %0d credit counter above queue depth", b);
        fail_cnt++;
      end
  end

  one_grant: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    $onehot0(dma_yumi_i))
    else begin
      $error("more than one bank granted in a cycle");
      fail_cnt++;
    end

  // fill is a single-cycle pulse
  fill_single_cycle: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    fill_v_i |=> !fill_v_i)
    else begin
      $error("fill valid held longer than one cycle");
      fail_cnt++;
    end

endmodule

bind vcache_top vcache_chk chk (
  .core_clk   (core_clk),
  .rst_n_i    (rst_n_i),
  .resp_v_i   (resp_v_o),
  .bank_v_i   (bank_v),
  .credit_i   (router.credit_q),
  .dma_yumi_i (dma_yumi),
  .fill_v_i   (fill_v)
);

/* verification/vcache_tb.sv */
// random and directed loads and stores against a word-level reference model
// addresses stay below 4096 so tags fit the backing memory without aliasing
`timescale 1ns/1ps
`include "vcache_cfg.svh"

module vcache_tb;

  import vcache_pkg::*;

  localparam int          NB             = `VC_NUM_BANKS;
  localparam int          BANK_BITS      = $clog2(`VC_NUM_BANKS);
  localparam logic [31:0] SEED           = 32'h398128e1;
  localparam int          N_RANDOM       = 200;
  localparam int          N_DIRECTED     = 24;
  localparam int          TIMEOUT_CYCLES = 200 * (N_RANDOM + N_DIRECTED);

  logic                 core_clk = 1'b0;
  logic                 rst_n_i;
  logic                 req_v_i;
  vc_req_s              req_i;
  logic                 req_ready_o;
  logic [NB-1:0]        resp_v_o;
  vc_resp_s [NB-1:0]    resp_o;

  logic [31:0] ref_mem [logic [15:0]];
  logic [15:0] written [$];
  vc_resp_s    exp_q [NB][$];
  int          err_cnt   = 0;
  int          stall_cnt = 0;
  int unsigned cycle_cnt = 0;

  vcache_top DUT (
    .core_clk    (core_clk),
    .rst_n_i     (rst_n_i),
    .req_v_i     (req_v_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .resp_v_o    (resp_v_o),
    .resp_o      (resp_o)
  );

  always #5 core_clk = ~core_clk;

  always @(posedge core_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // responses are stable at the falling edge
  always @(negedge core_clk) begin
    vc_resp_s want;
    if (rst_n_i) begin
      for (int b = 0; b < NB; b++) begin
        if (resp_v_o[b]) begin
          assert (exp_q[b].size() != 0) else begin
            $display("Bank %0d returned a response with no load outstanding", b);
            err_cnt++;
          end
          if (exp_q[b].size() != 0) begin
            want = exp_q[b].pop_front();
            assert (resp_o[b] === want) else begin
              $display("Mismatch at %0t: bank %0d got %h/%h expected %h/%h", $time, b,
                       resp_o[b].addr, resp_o[b].data, want.addr, want.data);
              err_cnt++;
            end
          end
        end
      end
    end
  end

  function automatic int pending_loads();
    int n;
    n = 0;
    for (int b = 0; b < NB; b++) begin
      n += exp_q[b].size();
    end
    return n;
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic send(input vc_op_e op, input logic [15:0] addr, input logic [31:0] data);
    logic     ready;
    vc_resp_s want;
    req_v_i    = 1'b1;
    req_i.op   = op;
    req_i.addr = addr;
    req_i.data = data;
    ready      = 1'b0;
    while (!ready) begin
      @(negedge core_clk);
      ready = req_ready_o;
      if (!ready) stall_cnt++;
      @(posedge core_clk);
      #1;
    end
    if (op == OP_STORE) begin
      if (!ref_mem.exists(addr)) written.push_back(addr);
      ref_mem[addr] = data;
    end else begin
      want.addr = addr;
      want.data = ref_mem[addr];
      exp_q[addr[BANK_BITS-1:0]].push_back(want);
    end
    req_v_i = 1'b0;
  endtask

  initial begin
    logic [15:0] base;
    logic [15:0] a1;
    logic [15:0] a2;
    logic [3:0]  tag;
    logic [3:0]  set;
    logic [1:0]  bb;
    void'($urandom(SEED));
    rst_n_i = 1'b0;
    req_v_i = 1'b0;
    req_i   = '0;
    repeat (5) @(posedge core_clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge core_clk);
    assert (req_ready_o) else begin
      $display("req_ready_o is low right after reset");
      err_cnt++;
    end
    @(posedge core_clk);
    #1;

    // store then load, same word
    a1 = 16'($urandom) & 16'h0FFF;
    send(OP_STORE, a1, $urandom);
    send(OP_LOAD, a1, '0);

    // same bank and set, two tags
    base = 16'($urandom) & 16'h00FF;
    tag  = 4'($urandom);
    a1   = base | {4'h0, tag, 8'h00};
    a2   = base | {4'h0, tag + 4'd1, 8'h00};
    send(OP_STORE, a1, $urandom);
    send(OP_STORE, a2, $urandom);
    send(OP_LOAD, a1, '0);
    send(OP_LOAD, a2, '0);

    for (int i = 0; i < N_RANDOM; i++) begin
      if (written.size() == 0 || $urandom % 2 == 0) begin
        send(OP_STORE, 16'($urandom) & 16'h0FFF, $urandom);
      end else begin
        send(OP_LOAD, written[$urandom % written.size()], '0);
      end
    end

    // back to back into one bank, misses fill its queue
    bb        = 2'($urandom);
    stall_cnt = 0;
    for (int k = 0; k < 3; k++) begin
      send(OP_STORE, {4'h0, 4'(k), 4'(k), 2'b00, bb}, $urandom);
    end
    for (int k = 0; k < 3; k++) begin
      send(OP_LOAD, {4'h0, 4'(k), 4'(k), 2'b00, bb}, '0);
    end
    assert (stall_cnt > 0) else begin
      $display("req_ready_o never fell during the single-bank burst");
      err_cnt++;
    end

    // misses in every bank at once
    set = 4'($urandom);
    for (int b = 0; b < NB; b++) begin
      send(OP_STORE, {4'h0, 4'hE, set, 2'b01, 2'(b)}, $urandom);
    end
    for (int b = 0; b < NB; b++) begin
      send(OP_STORE, {4'h0, 4'hF, set, 2'b01, 2'(b)}, $urandom);
    end
    for (int b = 0; b < NB; b++) begin
      send(OP_LOAD, {4'h0, 4'hE, set, 2'b01, 2'(b)}, '0);
    end

    while (pending_loads() != 0) @(posedge core_clk);
    repeat (10) @(posedge core_clk);

    $display("Checks done: %0d model errors, %0d assertion failures",
             err_cnt, DUT.chk.fail_cnt);
    if (err_cnt == 0 && DUT.chk.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
common/vcache_pkg.sv
design/vcache_router.sv
vcache/vcache_bank.sv
design/dma_mem_arbiter.sv
design/vcache_top.sv
verification/vcache_chk.sv
verification/vcache_tb.sv
